// ==== src/df_pkg.sv ====
/*
 * shared definitions for the dataflow steering stage
 * path index type and default sizes
 */
`default_nettype none

package df_pkg;

	// ------------------------------
	// path index
	// ------------------------------

	// carried with every output token
	// 0 is the buffered path, 1 the FIFO path
	typedef enum logic {
		PATH_BUF  = 1'b0,
		PATH_FIFO = 1'b1
	} path_e;

	// ------------------------------
	// default sizes
	// ------------------------------

	// payload width
	localparam int DATA_W_DEF = 32;

	// FIFO entries, power of two
	localparam int FIFO_DEPTH_DEF = 8;

endpackage

`default_nettype wire

// ==== src/df_branch.sv ====
/*
 * branch node: joins a data stream with a one-bit condition stream
 * and steers the joined token onto path 0 or path 1
 */
`timescale 1ns/1ps
`default_nettype none

module df_branch #(
	parameter int DATA_W = df_pkg::DATA_W_DEF
) (
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic              cond_in,
	input  logic              cond_valid,
	output logic              cond_ready,
	output logic [DATA_W-1:0] b0_data,
	output logic              b0_valid,
	input  logic              b0_ready,
	output logic [DATA_W-1:0] b1_data,
	output logic              b1_valid,
	input  logic              b1_ready
);

	import df_pkg::*;

	path_e sel;
	logic  join_valid;
	logic  join_ready;

	// condition bit maps straight onto the path index
	assign sel = path_e'(cond_in);

	// a token exists only once both halves are present
	assign join_valid = in_valid & cond_valid;

	// ready of whichever path the condition points at
	assign join_ready = (sel == PATH_BUF) ? b0_ready : b1_ready;

	// both inputs are consumed together or not at all
	assign in_ready   = join_valid & join_ready;
	assign cond_ready = join_valid & join_ready;

	// only the selected path sees a valid
	assign b0_valid = join_valid & (sel == PATH_BUF);
	assign b1_valid = join_valid & (sel == PATH_FIFO);

	// payload goes out unchanged on both sides
	assign b0_data = in_data;
	assign b1_data = in_data;

endmodule

`default_nettype wire

// ==== src/df_tehb.sv ====
/*
 * transparent half buffer
 * passes tokens through, parks one in a register when the output stalls
 */
`timescale 1ns/1ps
`default_nettype none

module df_tehb #(
	parameter int DATA_W = df_pkg::DATA_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [DATA_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic              full;
	logic [DATA_W-1:0] data_q;
	logic              load;

	// capture the passing token when the consumer refuses it
	assign load = in_valid & ~full & ~out_ready;

	// full follows any stalled output token
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			full <= 1'b0;
		else
			full <= out_valid & ~out_ready;
	end

	always_ff @(posedge clk) begin
		if (load)
			data_q <= in_data;
	end

	// register wins over the input while holding a token
	assign out_data  = full ? data_q : in_data;
	assign out_valid = in_valid | full;
	assign in_ready  = ~full;

endmodule

`default_nettype wire

// ==== src/df_oehb.sv ====
/*
 * opaque half buffer
 * registers valid and data, one cycle from input to output
 */
`timescale 1ns/1ps
`default_nettype none

module df_oehb #(
	parameter int DATA_W = df_pkg::DATA_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [DATA_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic              valid_q;
	logic [DATA_W-1:0] data_q;

	// slot frees up in the same cycle the consumer takes it
	assign in_ready = ~valid_q | out_ready;

	// valid only updates when the slot can change owner
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid_q <= 1'b0;
		else if (in_ready)
			valid_q <= in_valid;
	end

	// load on every input transfer
	always_ff @(posedge clk) begin
		if (in_valid & in_ready)
			data_q <= in_data;
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== src/df_fifo.sv ====
/*
 * transparent FIFO on a ring memory
 * tokens bypass the storage when it is empty and the consumer is ready
 */
`timescale 1ns/1ps
`default_nettype none

module df_fifo #(
	parameter int DATA_W     = df_pkg::DATA_W_DEF,
	parameter int FIFO_DEPTH = df_pkg::FIFO_DEPTH_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [DATA_W-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	localparam int               PTR_W    = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);

	// ------------------------------
	// storage and pointers
	// ------------------------------

	logic [DATA_W-1:0] mem [FIFO_DEPTH];

	// head is the oldest entry, tail the next free slot
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] head_nxt;
	logic [PTR_W-1:0] tail_nxt;

	logic full;
	logic empty;

	// internal valid, storage holds at least one token
	logic store_valid;

	logic wr_en;
	logic rd_en;

	assign store_valid = ~empty;

	// wrap at the last slot
	assign head_nxt = (head == PTR_LAST) ? '0 : head + 1'b1;
	assign tail_nxt = (tail == PTR_LAST) ? '0 : tail + 1'b1;

	// ------------------------------
	// handshake and bypass
	// ------------------------------

	// refuse only when full and nobody drains this cycle
	assign in_ready = ~full | out_ready;

	// stored tokens go first to keep order
	assign out_valid = in_valid | store_valid;
	assign out_data  = store_valid ? mem[head] : in_data;

	// write unless the token is bypassed straight out
	assign wr_en = in_valid & in_ready & (store_valid | ~out_ready);

	// read the head on a consumer transfer
	assign rd_en = store_valid & out_ready;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[tail] <= in_data;
	end

	// ------------------------------
	// pointer and flag update
	// ------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tail <= '0;
		end else if (wr_en) begin
			tail <= tail_nxt;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head <= '0;
		end else if (rd_en) begin
			head <= head_nxt;
		end
	end

	// flags change only when read and write differ
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else if (wr_en & ~rd_en) begin
			// tail catching up with head
			full <= (tail_nxt == head);
		end else if (rd_en & ~wr_en) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			empty <= 1'b1;
		end else if (rd_en & ~wr_en) begin
			// head catching up with tail
			empty <= (head_nxt == tail);
		end else if (wr_en & ~rd_en) begin
			empty <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/df_merge.sv ====
/*
 * fixed-priority two-input merge, input 0 first
 * the winner's index travels with the data through an output TEHB
 */
`timescale 1ns/1ps
`default_nettype none

module df_merge #(
	parameter int DATA_W = df_pkg::DATA_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] a0_data,
	input  logic              a0_valid,
	output logic              a0_ready,
	input  logic [DATA_W-1:0] a1_data,
	input  logic              a1_valid,
	output logic              a1_ready,
	output logic [DATA_W-1:0] out_data,
	output df_pkg::path_e     out_path,
	output logic              out_valid,
	input  logic              out_ready
);

	import df_pkg::*;

	path_e           sel;
	logic            pick_valid;
	logic [DATA_W:0] pick_data;
	logic            tehb_ready;
	logic [DATA_W:0] tehb_out;

	// lowest valid input wins
	assign sel        = a0_valid ? PATH_BUF : PATH_FIFO;
	assign pick_valid = a0_valid | a1_valid;

	// index on top, payload below
	assign pick_data = {sel, (sel == PATH_BUF) ? a0_data : a1_data};

	// input 1 is held off while input 0 is offering
	// so a masked token is never seen as consumed
	assign a0_ready = tehb_ready;
	assign a1_ready = tehb_ready & ~a0_valid;

	df_tehb #(
		.DATA_W(DATA_W + 1)
	) u_tehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (pick_data),
		.in_valid (pick_valid),
		.in_ready (tehb_ready),
		.out_data (tehb_out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	// unpack index and payload
	assign out_path = path_e'(tehb_out[DATA_W]);
	assign out_data = tehb_out[DATA_W-1:0];

endmodule

`default_nettype wire

// ==== src/df_steer_top.sv ====
/*
 * elastic steering stage: join and branch, buffered path 0,
 * FIFO path 1, priority merge back onto one output stream
 */
`timescale 1ns/1ps
`default_nettype none

module df_steer_top #(
	parameter int DATA_W     = df_pkg::DATA_W_DEF,
	parameter int FIFO_DEPTH = df_pkg::FIFO_DEPTH_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic              cond_in,
	input  logic              cond_valid,
	output logic              cond_ready,
	output logic [DATA_W-1:0] out_data,
	output df_pkg::path_e     out_path,
	output logic              out_valid,
	input  logic              out_ready
);

	// branch outputs
	logic [DATA_W-1:0] b0_data;
	logic              b0_valid;
	logic              b0_ready;
	logic [DATA_W-1:0] b1_data;
	logic              b1_valid;
	logic              b1_ready;

	// path 0 between its two half buffers
	logic [DATA_W-1:0] t0_data;
	logic              t0_valid;
	logic              t0_ready;

	// merge inputs
	logic [DATA_W-1:0] a0_data;
	logic              a0_valid;
	logic              a0_ready;
	logic [DATA_W-1:0] a1_data;
	logic              a1_valid;
	logic              a1_ready;

	df_branch #(.DATA_W(DATA_W)) u_branch (
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.cond_in   (cond_in),
		.cond_valid(cond_valid),
		.cond_ready(cond_ready),
		.b0_data   (b0_data),
		.b0_valid  (b0_valid),
		.b0_ready  (b0_ready),
		.b1_data   (b1_data),
		.b1_valid  (b1_valid),
		.b1_ready  (b1_ready)
	);

	// ------------------------------
	// path 0, TEHB then OEHB
	// ------------------------------
	df_tehb #(.DATA_W(DATA_W)) u_p0_tehb (
		.clk(clk), .rst(rst),
		.in_data(b0_data), .in_valid(b0_valid), .in_ready(b0_ready),
		.out_data(t0_data), .out_valid(t0_valid), .out_ready(t0_ready)
	);

	df_oehb #(.DATA_W(DATA_W)) u_p0_oehb (
		.clk(clk), .rst(rst),
		.in_data(t0_data), .in_valid(t0_valid), .in_ready(t0_ready),
		.out_data(a0_data), .out_valid(a0_valid), .out_ready(a0_ready)
	);

	// path 1
	df_fifo #(.DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) u_p1_fifo (
		.clk(clk), .rst(rst),
		.in_data(b1_data), .in_valid(b1_valid), .in_ready(b1_ready),
		.out_data(a1_data), .out_valid(a1_valid), .out_ready(a1_ready)
	);

	df_merge #(.DATA_W(DATA_W)) u_merge (
		.clk(clk), .rst(rst),
		.a0_data(a0_data), .a0_valid(a0_valid), .a0_ready(a0_ready),
		.a1_data(a1_data), .a1_valid(a1_valid), .a1_ready(a1_ready),
		.out_data(out_data), .out_path(out_path),
		.out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

`default_nettype wire

// ==== verif/df_steer_sva.sv ====
/*
 * handshake assertions for the steering stage, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module df_steer_sva #(
	parameter int DATA_W = df_pkg::DATA_W_DEF
) (
	input logic              clk,
	input logic              rst,
	input logic              in_valid,
	input logic              in_ready,
	input logic              cond_valid,
	input logic              cond_ready,
	input logic [DATA_W-1:0] out_data,
	input logic              out_valid,
	input logic              out_ready
);

	// stalled output keeps valid and payload
	assert property (@(posedge clk) disable iff (rst)
		(out_valid & ~out_ready) |=> (out_valid && $stable(out_data)))
		else $error("output token changed while stalled");

	// joined streams accept together and only with both tokens present
	assert property (@(posedge clk)
		(in_ready == cond_ready) && (!in_ready || (in_valid && cond_valid)))
		else $error("in_ready and cond_ready differ or rise without both valid");

	// nothing leaves while in reset
	assert property (@(posedge clk) rst |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind df_steer_top df_steer_sva #(.DATA_W(DATA_W)) u_sva (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.cond_valid(cond_valid),
	.cond_ready(cond_ready),
	.out_data  (out_data),
	.out_valid (out_valid),
	.out_ready (out_ready)
);

`default_nettype wire

// ==== verif/tb_df_steer.sv ====
/*
 * testbench for the steering stage: random traffic against per-path
 * queues, back-pressure capacity, merge priority and latency
 */
`timescale 1ns/1ps
`default_nettype none

module tb_df_steer;

	import df_pkg::*;

	localparam int W           = DATA_W_DEF;
	localparam int DEPTH       = FIFO_DEPTH_DEF;
	localparam int RAND_TOKENS = 2000;
	localparam int LAT_TOKENS  = 64;
	localparam int DRAIN_MAX   = 4 * DEPTH + 64;
	// cycle budget of all tests, watchdog allows 20 ns per cycle
	localparam int TOTAL_CYCLES = 8 * RAND_TOKENS + 16 * LAT_TOKENS + 6 * DRAIN_MAX;

	logic         clk;
	logic         rst;
	logic [W-1:0] in_data;
	logic         in_valid;
	logic         in_ready;
	logic         cond_in;
	logic         cond_valid;
	logic         cond_ready;
	logic [W-1:0] out_data;
	path_e        out_path;
	logic         out_valid;
	logic         out_ready;

	// reference model, one queue per path plus transfer cycle stamps
	logic [W-1:0] q0[$];
	logic [W-1:0] q1[$];
	int           c0[$];
	int           c1[$];
	path_e        path_log[$];

	logic [31:0]  seed = 32'h5275_47d3;
	logic [W-1:0] exp_data;
	int           stamp;
	logic         have;
	logic         in_xfer = 1'b0;
	logic         lat_on = 1'b0;
	int           cyc = 0;
	int           n_in = 0;
	int           n_cond = 0;
	int           n_out = 0;
	int           checks = 0;
	int           errors = 0;
	int           err_mark = 0;

	df_steer_top #(.DATA_W(W), .FIFO_DEPTH(DEPTH)) DUT (
		.clk(clk), .rst(rst),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.cond_in(cond_in), .cond_valid(cond_valid), .cond_ready(cond_ready),
		.out_data(out_data), .out_path(out_path),
		.out_valid(out_valid), .out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// LCG, numerical recipes constants
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error: %s = %0h, expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report(input string name);
		$display("test %-14s %s (%0d errors)", name,
			(errors == err_mark) ? "ok" : "mismatch", errors - err_mark);
		err_mark = errors;
	endtask

	// ------------------------------
	// monitor and reference model
	// ------------------------------

	// falling edge, every level settled and inputs stable until next rise
	always @(negedge clk) begin
		cyc = cyc + 1;
		in_xfer = in_valid & in_ready;
		if (!rst) begin
			checks++;
			// data and condition move together or not at all
			assert (in_xfer == (cond_valid & cond_ready)) else begin
				$display("data and condition streams transferred separately");
				errors++;
			end
			// push before pop, path 1 may bypass in the same cycle
			if (in_xfer) begin
				n_in++;
				if (cond_in) begin
					q1.push_back(in_data);
					c1.push_back(cyc);
				end else begin
					q0.push_back(in_data);
					c0.push_back(cyc);
				end
			end
			if (cond_valid & cond_ready)
				n_cond++;
			if (out_valid & out_ready) begin
				n_out++;
				path_log.push_back(out_path);
				have = 1'b0;
				if (out_path == PATH_BUF && q0.size() != 0) begin
					exp_data = q0.pop_front();
					stamp = c0.pop_front();
					have = 1'b1;
				end else if (out_path == PATH_FIFO && q1.size() != 0) begin
					exp_data = q1.pop_front();
					stamp = c1.pop_front();
					have = 1'b1;
				end
				checks++;
				assert (have) else begin
					$display("output on path %0d while no token was expected there", out_path);
					errors++;
				end
				if (have) begin
					check_eq("out_data", out_data, exp_data);
					// path 0 one cycle through the OEHB, path 1 bypassed
					if (lat_on)
						check_eq("out latency", cyc - stamp, (out_path == PATH_BUF) ? 1 : 0);
				end
			end
		end
	end

	// ------------------------------
	// stimulus tasks
	// ------------------------------

	task automatic do_reset(input logic ready);
		@(posedge clk);
		rst        <= 1'b1;
		in_valid   <= 1'b0;
		cond_valid <= 1'b0;
		out_ready  <= ready;
		q0.delete();
		q1.delete();
		c0.delete();
		c1.delete();
		path_log.delete();
		n_in = 0;
		n_cond = 0;
		n_out = 0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic run_random();
		logic [31:0] r;
		while (n_in < RAND_TOKENS) begin
			@(posedge clk);
			r = next_rand();
			// roughly three cycles in four ready
			out_ready <= (r[31:30] != 2'b00);
			// a pending token is held until taken
			if (!in_valid || in_xfer) begin
				in_valid <= (r[29:28] != 2'b00);
				in_data  <= next_rand();
			end
			if (!cond_valid || in_xfer) begin
				cond_valid <= (r[27:26] != 2'b00);
				cond_in    <= r[25];
			end
		end
	endtask

	// same condition offered every cycle for a window
	task automatic offer(input logic c, input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			if (!in_valid || in_xfer)
				in_data <= next_rand();
			in_valid   <= 1'b1;
			cond_valid <= 1'b1;
			cond_in    <= c;
		end
		@(posedge clk);
		in_valid   <= 1'b0;
		cond_valid <= 1'b0;
	endtask

	task automatic drain();
		int n;
		@(posedge clk);
		in_valid   <= 1'b0;
		cond_valid <= 1'b0;
		out_ready  <= 1'b1;
		n = 0;
		while (q0.size() + q1.size() != 0 && n < DRAIN_MAX) begin
			@(posedge clk);
			n++;
		end
		// a few idle cycles so a stray extra token shows up
		repeat (4) @(posedge clk);
		checks++;
		assert (q0.size() + q1.size() == 0) else begin
			$display("drain ran out of time with %0d tokens still expected",
				q0.size() + q1.size());
			errors++;
		end
		check_eq("output token count", n_out, n_in);
		check_eq("cond token count", n_cond, n_in);
	endtask

	task automatic run_latency();
		logic [31:0] r;
		lat_on = 1'b1;
		repeat (LAT_TOKENS) begin
			@(posedge clk);
			r = next_rand();
			in_data    <= next_rand();
			cond_in    <= r[31];
			in_valid   <= 1'b1;
			cond_valid <= 1'b1;
			do @(posedge clk); while (!in_xfer);
			in_valid   <= 1'b0;
			cond_valid <= 1'b0;
			// one token in flight, no contention at the merge
			while (q0.size() + q1.size() != 0)
				@(posedge clk);
		end
		lat_on = 1'b0;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		rst        = 1'b1;
		in_data    = '0;
		in_valid   = 1'b0;
		cond_in    = 1'b0;
		cond_valid = 1'b0;
		out_ready  = 1'b0;

		do_reset(1'b1);
		@(negedge clk);
		check_eq("out_valid", out_valid, 0);
		check_eq("in_ready", in_ready, 0);
		check_eq("cond_ready", cond_ready, 0);
		report("reset");

		run_random();
		drain();
		report("random");

		// merge TEHB plus a full FIFO
		do_reset(1'b0);
		offer(1'b1, DEPTH + 8);
		check_eq("accepted on path 1", n_in, DEPTH + 1);
		drain();
		report("capacity_fifo");

		// merge TEHB, OEHB and path TEHB
		do_reset(1'b0);
		offer(1'b0, 10);
		check_eq("accepted on path 0", n_in, 3);
		drain();
		report("capacity_buf");

		// both paths loaded, path 0 must empty before path 1 continues
		do_reset(1'b0);
		offer(1'b0, 6);
		offer(1'b1, DEPTH + 4);
		path_log.delete();
		drain();
		for (int i = 1; i < path_log.size(); i++) begin
			checks++;
			assert (!(path_log[i-1] == PATH_FIFO && path_log[i] == PATH_BUF)) else begin
				$display("path 0 token left after a path 1 token at drain position %0d", i);
				errors++;
			end
		end
		report("priority");

		do_reset(1'b1);
		run_latency();
		drain();
		report("latency");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(TOTAL_CYCLES * 20);
		$display("watchdog: run did not complete within %0d cycles", TOTAL_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== df_steer_top.f ====
src/df_pkg.sv
src/df_branch.sv
src/df_tehb.sv
src/df_oehb.sv
src/df_fifo.sv
src/df_merge.sv
src/df_steer_top.sv
verif/df_steer_sva.sv
verif/tb_df_steer.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the steering stage testbench with Verilator
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_df_steer -Mdir "$OBJ" \
	-f df_steer_top.f
if [ $? -ne 0 ]; then
	echo "verilator build returned an error"
	exit 1
fi

"./$OBJ/Vtb_df_steer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi
exit 0
